//--- include/audgen_defines.svh
// audio generator shared sizes
// slot counts, sample width, clock divider and synchronizer depth

`ifndef AUDGEN_DEFINES_SVH
`define AUDGEN_DEFINES_SVH

////////////////////////////////////////
// serial frame geometry

// bit-clock slots in one channel half
`define AUDGEN_SLOT_BITS 32

// data slots at the start of each half, the rest are dummy
`define AUDGEN_ACTIVE_BITS 16

// one sample word, spans both halves of a frame
`define AUDGEN_SAMPLE_BITS 32

////////////////////////////////////////
// clocking

// mclk to sclk divider width, divide by four
`define AUDGEN_SCLK_DIV_BITS 2

// flops per buzzer line before the mixer
`define AUDGEN_SYNC_STAGES 3

`endif

//--- logic/audio_pkg.sv
// audio sample package
// sample word type, buzzer mix levels and the sample value for each level

`include "audgen_defines.svh"

package audio_pkg;

  // one mixed sample, unsigned
  typedef logic [`AUDGEN_SAMPLE_BITS-1:0] sample_t;

  // number of buzzers currently high
  typedef enum logic [1:0]
  {
    MIX_SILENT = 2'd0,
    MIX_SINGLE = 2'd1,
    MIX_DOUBLE = 2'd2
  } mix_level_e;

  // each buzzer adds ones in the low bits, top two bits stay clear
  localparam int MIX_ONE_BITS = `AUDGEN_SAMPLE_BITS - 2;

  localparam sample_t SAMPLE_SILENT = '0;
  localparam sample_t SAMPLE_SINGLE = {2'b00, {MIX_ONE_BITS{1'b1}}};
  // sum of two single contributions, no overflow into bit 31
  localparam sample_t SAMPLE_DOUBLE = SAMPLE_SINGLE + SAMPLE_SINGLE;

endpackage

//--- logic/i2s_pkg.sv
// i2s frame package
// word-select encoding and slot counter type for the serial output

`include "audgen_defines.svh"

package i2s_pkg;

  // word-select level, a frame starts with the rise to CHAN_HIGH
  typedef enum logic
  {
    CHAN_LOW  = 1'b0,
    CHAN_HIGH = 1'b1
  } i2s_channel_e;

  // slot index inside one channel half
  typedef logic [$clog2(`AUDGEN_SLOT_BITS)-1:0] slot_t;

  // last slot of a half, lrck flips after it
  localparam slot_t SLOT_LAST = slot_t'(`AUDGEN_SLOT_BITS - 1);

  // first dummy slot, data only below this index
  localparam slot_t SLOT_ACTIVE_END = slot_t'(`AUDGEN_ACTIVE_BITS);

  // one step of the slot counter, wraps from the last slot to zero
  function automatic slot_t slot_next(input slot_t slot);
    slot_next = slot_t'(slot + 1'b1);
  endfunction

endpackage

//--- logic/buzzer_mix.sv
// buzzer mixer
// brings both buzzer lines into the mclk domain and forms the
// registered sample word from the number of buzzers that are high

`timescale 1ns/100ps

`include "audgen_defines.svh"

module buzzer_mix
  import audio_pkg::*;
(
  input  logic    audgen_mclk,
  input  logic    arst_n,
  input  logic    buzzer1,
  input  logic    buzzer2,
  output sample_t sample
);

  logic [`AUDGEN_SYNC_STAGES-1:0] sync1;
  logic [`AUDGEN_SYNC_STAGES-1:0] sync2;
  logic                           buzzer1_s;
  logic                           buzzer2_s;
  mix_level_e                     level;
  sample_t                        sample_q;

  ////////////////////////////////////////
  // synchronizers

  // buzzer lines come from an unrelated domain
  always_ff @(posedge audgen_mclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync1 <= '0;
      sync2 <= '0;
    end
    else
    begin
      sync1 <= {sync1[`AUDGEN_SYNC_STAGES-2:0], buzzer1};
      sync2 <= {sync2[`AUDGEN_SYNC_STAGES-2:0], buzzer2};
    end
  end

  assign buzzer1_s = sync1[`AUDGEN_SYNC_STAGES-1];
  assign buzzer2_s = sync2[`AUDGEN_SYNC_STAGES-1];

  ////////////////////////////////////////
  // mix

  always_comb
  begin
    unique case ({buzzer1_s, buzzer2_s})
      2'b00:          level = MIX_SILENT;
      2'b01, 2'b10:   level = MIX_SINGLE;
      default:        level = MIX_DOUBLE;
    endcase
  end

  // one register stage after the synchronizer
  always_ff @(posedge audgen_mclk or negedge arst_n)
  begin
    if (!arst_n)
      sample_q <= SAMPLE_SILENT;
    else
    begin
      unique case (level)
        MIX_SILENT: sample_q <= SAMPLE_SILENT;
        MIX_SINGLE: sample_q <= SAMPLE_SINGLE;
        default:    sample_q <= SAMPLE_DOUBLE;
      endcase
    end
  end

  assign sample = sample_q;

endmodule

//--- logic/i2s_serializer.sv
// i2s serializer
// divides mclk by four for the bit clock, counts slots per half,
// drives word-select and shifts the sample out MSB first

`timescale 1ns/100ps

`include "audgen_defines.svh"

module i2s_serializer
  import audio_pkg::*;
  import i2s_pkg::*;
(
  input  logic    audgen_mclk,
  input  logic    arst_n,
  input  sample_t sample,
  output logic    sclk,
  output logic    lrck,
  output logic    dac
);

  logic [`AUDGEN_SCLK_DIV_BITS-1:0] div_cnt;
  logic                             sclk_fall;
  slot_t                            slot_cnt;
  logic                             slot_wrap;
  logic                             active_slot;
  i2s_channel_e                     chan;
  logic                             frame_start;
  sample_t                          shifter;
  logic                             dac_q;

  ////////////////////////////////////////
  // bit clock

  // free-running, sclk is the divider MSB
  always_ff @(posedge audgen_mclk or negedge arst_n)
  begin
    if (!arst_n)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  assign sclk = div_cnt[`AUDGEN_SCLK_DIV_BITS-1];

  // divider about to roll over, sclk drops on this edge
  assign sclk_fall = &div_cnt;

  ////////////////////////////////////////
  // slot counter and word select

  assign slot_wrap   = (slot_cnt == SLOT_LAST);
  assign active_slot = (slot_cnt < SLOT_ACTIVE_END);

  // low to high on lrck opens a new frame
  assign frame_start = slot_wrap && (chan == CHAN_LOW);

  always_ff @(posedge audgen_mclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      slot_cnt <= '0;
      chan     <= CHAN_LOW;
    end
    else if (sclk_fall)
    begin
      slot_cnt <= slot_next(slot_cnt);
      if (slot_wrap)
        chan <= (chan == CHAN_LOW) ? CHAN_HIGH : CHAN_LOW;
    end
  end

  ////////////////////////////////////////
  // data shifter

  // one word covers both halves, so no reload on the falling lrck
  always_ff @(posedge audgen_mclk or negedge arst_n)
  begin
    if (!arst_n)
      shifter <= '0;
    else if (sclk_fall)
    begin
      if (frame_start)
        shifter <= sample;
      else if (active_slot)
        shifter <= {shifter[`AUDGEN_SAMPLE_BITS-2:0], 1'b0};
    end
  end

  // data trails lrck by one slot, dummy slots send zero
  always_ff @(posedge audgen_mclk or negedge arst_n)
  begin
    if (!arst_n)
      dac_q <= 1'b0;
    else if (sclk_fall)
      dac_q <= active_slot ? shifter[`AUDGEN_SAMPLE_BITS-1] : 1'b0;
  end

  assign lrck = chan;
  assign dac  = dac_q;

endmodule

//--- logic/audgen_top.sv
// audio generator top level
// buzzer mixer feeding the i2s serializer, all on mclk

`timescale 1ns/100ps

module audgen_top
  import audio_pkg::*;
(
  input  logic audgen_mclk,
  input  logic arst_n,
  input  logic buzzer1,
  input  logic buzzer2,
  output logic audio_sclk,
  output logic audio_lrck,
  output logic audio_dac
);

  // mixed word, picked up by the serializer at each frame start
  sample_t sample;

  ////////////////////////////////////////
  // mixer

  buzzer_mix i_buzzer_mix
  (
    .audgen_mclk (audgen_mclk),
    .arst_n      (arst_n),
    .buzzer1     (buzzer1),
    .buzzer2     (buzzer2),
    .sample      (sample)
  );

  ////////////////////////////////////////
  // serial output

  i2s_serializer i_i2s_serializer
  (
    .audgen_mclk (audgen_mclk),
    .arst_n      (arst_n),
    .sample      (sample),
    .sclk        (audio_sclk),
    .lrck        (audio_lrck),
    .dac         (audio_dac)
  );

endmodule

//--- test/audgen_clkgen.sv
// testbench clock and reset
// mclk with a fixed period, reset held low for a few cycles

`timescale 1ns/100ps

module audgen_clkgen
#(
  parameter real PERIOD_NS    = 10.0,
  parameter int  RESET_CYCLES = 5
)
(
  output logic audgen_mclk,
  output logic arst_n
);

  initial
  begin
    audgen_mclk = 1'b0;
    forever #(PERIOD_NS / 2.0) audgen_mclk = ~audgen_mclk;
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge audgen_mclk);
    @(negedge audgen_mclk);
    arst_n = 1'b1;
  end

endmodule

//--- test/audgen_asserts.sv
// serial timing checks for the i2s serializer
// bound into every serializer instance

`timescale 1ns/100ps

`include "audgen_defines.svh"

module audgen_asserts
  import i2s_pkg::*;
(
  input logic  audgen_mclk,
  input logic  arst_n,
  input logic  sclk,
  input logic  lrck,
  input logic  dac,
  input slot_t slot_cnt
);

  int fail_cnt = 0;

  ////////////////////////////////////////
  // outputs move only on the falling bit clock

  lrck_on_fall: assert property (@(posedge audgen_mclk) disable iff (!arst_n)
    $changed(lrck) |-> $fell(sclk))
    else
    begin
      fail_cnt++;
      $error("lrck changed in a cycle where sclk did not fall");
    end

  dac_on_fall: assert property (@(posedge audgen_mclk) disable iff (!arst_n)
    $changed(dac) |-> $fell(sclk))
    else
    begin
      fail_cnt++;
      $error("dac changed in a cycle where sclk did not fall");
    end

  // data trails the slot count by one, so only slots 1 to 16 carry bits
  dac_zero_dummy: assert property (@(posedge audgen_mclk) disable iff (!arst_n)
    (slot_cnt == '0 || slot_cnt > slot_t'(`AUDGEN_ACTIVE_BITS)) |-> !dac)
    else
    begin
      fail_cnt++;
      $error("dac high in a dummy slot");
    end

  ////////////////////////////////////////
  // bit clock duty

  sclk_high_two: assert property (@(posedge audgen_mclk) disable iff (!arst_n)
    $rose(sclk) |-> ##2 $fell(sclk))
    else
    begin
      fail_cnt++;
      $error("sclk high for other than 2 mclk cycles");
    end

  sclk_low_two: assert property (@(posedge audgen_mclk) disable iff (!arst_n)
    $fell(sclk) |-> ##2 $rose(sclk))
    else
    begin
      fail_cnt++;
      $error("sclk low for other than 2 mclk cycles");
    end

endmodule

bind i2s_serializer audgen_asserts i_asserts
(
  .audgen_mclk (audgen_mclk),
  .arst_n      (arst_n),
  .sclk        (sclk),
  .lrck        (lrck),
  .dac         (dac),
  .slot_cnt    (slot_cnt)
);

//--- test/audgen_tb.sv
// audio generator testbench
// drives buzzer pairs, captures the serial frames and compares
// each half word with the expected mix

`timescale 1ns/100ps

`include "audgen_defines.svh"

module audgen_tb
  import audio_pkg::*;
();

  localparam int FRAME_MCLKS  = 4 * 2 * `AUDGEN_SLOT_BITS;
  localparam int RANDOM_PAIRS = 8;
  localparam int FIXED_PAIRS  = 4;

  logic    audgen_mclk;
  logic    arst_n;
  logic    buzzer1;
  logic    buzzer2;
  wire     audio_sclk;
  wire     audio_lrck;
  wire     audio_dac;
  int      errors;
  int      checks;
  int      halves_checked;
  int      frame_cnt;
  int      slot_idx;
  logic    prev_lrck;
  logic    next_chk;
  logic    cur_chk;
  sample_t next_exp;
  sample_t cur_exp;
  logic [`AUDGEN_ACTIVE_BITS-1:0] half_word;

  audgen_clkgen i_clkgen
  (
    .audgen_mclk (audgen_mclk),
    .arst_n      (arst_n)
  );

  audgen_top i_dut
  (
    .audgen_mclk (audgen_mclk),
    .arst_n      (arst_n),
    .buzzer1     (buzzer1),
    .buzzer2     (buzzer2),
    .audio_sclk  (audio_sclk),
    .audio_lrck  (audio_lrck),
    .audio_dac   (audio_dac)
  );

  ////////////////////////////////////////
  // reference and check

  // sample word for the number of buzzers that are high
  function automatic sample_t expected_sample(input logic b1, input logic b2);
    int high;
    begin
      high = 0;
      if (b1)
        high++;
      if (b2)
        high++;
      case (high)
        0:       expected_sample = 32'h0000_0000;
        1:       expected_sample = 32'h3FFF_FFFF;
        default: expected_sample = 32'h7FFF_FFFE;
      endcase
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             i_dut.i_i2s_serializer.i_asserts.fail_cnt);
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    print_counts();
    $display("SIMULATION FAILED");
    $finish;
  endtask

  ////////////////////////////////////////
  // waits

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < 20)
    begin
      @(posedge audgen_mclk);
      #1;
      cycles++;
    end
    if (arst_n !== 1'b1)
      report_timeout("reset release");
  endtask

  task automatic wait_frames(input int n);
    int target;
    int cycles;
    target = frame_cnt + n;
    cycles = 0;
    while (frame_cnt < target && cycles < (n + 1) * FRAME_MCLKS)
    begin
      @(posedge audgen_mclk);
      #1;
      cycles++;
    end
    if (frame_cnt < target)
      report_timeout("a rising edge on audio_lrck");
  endtask

  // change right after a frame start and check the second full frame
  task automatic hold_pair(input logic b1, input logic b2);
    buzzer1  = b1;
    buzzer2  = b2;
    next_chk = 1'b0;
    wait_frames(1);
    next_exp = expected_sample(b1, b2);
    next_chk = 1'b1;
    wait_frames(1);
    next_chk = 1'b0;
    wait_frames(1);
  endtask

  ////////////////////////////////////////
  // frame capture and compare

  always @(posedge audio_sclk)
  begin
    if (audio_lrck !== prev_lrck)
    begin
      if (slot_idx != `AUDGEN_SLOT_BITS - 1)
      begin
        errors++;
        $display("audio_lrck toggled after %0d sclk periods", slot_idx + 1);
      end
      slot_idx  = 0;
      prev_lrck = audio_lrck;
      if (audio_lrck)
      begin
        frame_cnt++;
        cur_exp = next_exp;
        cur_chk = next_chk;
      end
    end
    else
      slot_idx++;
    // slot 0 of each half still carries the previous dummy
    if (slot_idx >= 1 && slot_idx <= `AUDGEN_ACTIVE_BITS)
      half_word = {half_word[`AUDGEN_ACTIVE_BITS-2:0], audio_dac};
    else
      check_value("audio_dac", audio_dac, 1'b0);
    if (slot_idx == `AUDGEN_ACTIVE_BITS && cur_chk)
    begin
      halves_checked++;
      check_value("audio_dac", half_word, audio_lrck ? cur_exp[31:16] : cur_exp[15:0]);
    end
  end

  ////////////////////////////////////////
  // stimulus

  initial
  begin
    logic [31:0] r;
    errors         = 0;
    checks         = 0;
    halves_checked = 0;
    frame_cnt      = 0;
    slot_idx       = -1;
    prev_lrck      = 1'b0;
    half_word      = '0;
    buzzer1        = 1'b0;
    buzzer2        = 1'b0;
    next_exp       = '0;
    next_chk       = 1'b0;
    cur_exp        = '0;
    cur_chk        = 1'b0;
    void'($urandom(32'hc163_2fb8));

    wait_reset_release();
    check_value("audio_sclk", audio_sclk, 1'b0);
    check_value("audio_lrck", audio_lrck, 1'b0);
    check_value("audio_dac", audio_dac, 1'b0);
    // one mclk edge out of reset has passed here
    for (int k = 2; k < 18; k++)
    begin
      @(posedge audgen_mclk);
      #1;
      check_value("audio_sclk", audio_sclk, (k % 4) >= 2);
    end

    wait_frames(1);
    hold_pair(1'b0, 1'b0);
    hold_pair(1'b1, 1'b0);
    hold_pair(1'b0, 1'b1);
    hold_pair(1'b1, 1'b1);
    repeat (RANDOM_PAIRS)
    begin
      r = $urandom;
      hold_pair(r[0], r[1]);
    end

    if (halves_checked != 2 * (FIXED_PAIRS + RANDOM_PAIRS))
    begin
      errors++;
      $display("only %0d of %0d halves were compared", halves_checked,
               2 * (FIXED_PAIRS + RANDOM_PAIRS));
    end
    print_counts();
    if (errors == 0 && i_dut.i_i2s_serializer.i_asserts.fail_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
logic/audio_pkg.sv
logic/i2s_pkg.sv
logic/buzzer_mix.sv
logic/i2s_serializer.sv
logic/audgen_top.sv
test/audgen_clkgen.sv
test/audgen_asserts.sv
test/audgen_tb.sv

//--- Bender.yml
package:
  name: audgen

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/audio_pkg.sv
      - logic/i2s_pkg.sv
      - logic/buzzer_mix.sv
      - logic/i2s_serializer.sv
      - logic/audgen_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/audgen_clkgen.sv
      - test/audgen_asserts.sv
      - test/audgen_tb.sv
